//--- compile.f
+incdir+include
hdl/rv_core_pkg.sv
hdl/hazard_if.sv
hdl/program_memory.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_stage.sv
hdl/hazard_control.sv
hdl/cpu.sv
verif/cpu_tb.sv

//--- hdl/cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module cpu (
    input  wire logic                    clk,
    input  wire logic                    reset_n,
    input  wire logic                    imem_load_en,
    input  wire logic [`IMEM_ADDR_W-1:0] imem_load_addr,
    input  wire logic [`XLEN-1:0]        imem_load_data,
    output logic                         retire_valid,
    output logic      [`REG_ADDR_W-1:0]  retire_rd,
    output logic      [`XLEN-1:0]        retire_data,
    output logic                         store_valid,
    output logic      [`XLEN-1:0]        store_addr,
    output logic      [`XLEN-1:0]        store_data
);

    import rv_core_pkg::*;

    hazard_if hz ();

    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] fetch_word;
    logic [`XLEN-1:0] dec_data1;
    logic [`XLEN-1:0] dec_data2;
    logic [`XLEN-1:0] dec_imm;
    ctrl_t            dec_ctrl;
    logic [`XLEN-1:0] ex_alu_data;
    logic [`XLEN-1:0] ex_store_data;
    logic             branch_taken;
    logic [`XLEN-1:0] branch_target;
    logic [`XLEN-1:0] mem_load_data;
    logic [`XLEN-1:0] wb_data;

    program_memory u_imem (
        .clk       (clk),
        .load_en   (imem_load_en),
        .load_addr (imem_load_addr),
        .load_data (imem_load_data),
        .read_addr (pc[`IMEM_ADDR_W+1:2]),
        .read_data (fetch_word)
    );

    fetch_stage u_fetch (
        .clk           (clk),
        .reset_n       (reset_n),
        .hz            (hz.dp),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .pc            (pc)
    );

    decode_stage u_decode (
        .clk       (clk),
        .reset_n   (reset_n),
        .instr     (if_id.instr),
        .wb_en     (mem_wb.ctrl.reg_write),
        .wb_rd     (mem_wb.rd),
        .wb_data   (wb_data),
        .data1     (dec_data1),
        .data2     (dec_data2),
        .immediate (dec_imm),
        .ctrl      (dec_ctrl)
    );

    execute_stage u_execute (
        .id_ex         (id_ex),
        .hz            (hz.dp),
        .mem_fwd_data  (ex_mem.alu_data),
        .wb_fwd_data   (wb_data),
        .alu_data      (ex_alu_data),
        .store_data    (ex_store_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    mem_stage u_mem (
        .clk       (clk),
        .ex_mem    (ex_mem),
        .load_data (mem_load_data)
    );

    hazard_control u_hazard (
        .if_id_rs1        (if_id.instr.rs1),
        .if_id_rs2        (if_id.instr.rs2),
        .id_ex_rs1        (id_ex.rs1),
        .id_ex_rs2        (id_ex.rs2),
        .id_ex_rd         (id_ex.rd),
        .id_ex_mem_read   (id_ex.ctrl.mem_read),
        .ex_mem_rd        (ex_mem.rd),
        .ex_mem_reg_write (ex_mem.ctrl.reg_write),
        .mem_wb_rd        (mem_wb.rd),
        .mem_wb_reg_write (mem_wb.ctrl.reg_write),
        .branch_taken     (branch_taken),
        .hz               (hz.ctrl)
    );

    // pipeline registers, flush beats hold
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            if_id  <= '0;
            id_ex  <= '0;
            ex_mem <= '0;
            mem_wb <= '0;
        end else begin
            if (hz.if_id_flush) begin
                if_id <= '0;
            end else if (hz.if_id_write) begin
                if_id.pc    <= pc;
                if_id.instr <= fetch_word;
            end

            id_ex.pc        <= if_id.pc;
            id_ex.rs1       <= if_id.instr.rs1;
            id_ex.rs2       <= if_id.instr.rs2;
            id_ex.rd        <= if_id.instr.rd;
            id_ex.data1     <= dec_data1;
            id_ex.data2     <= dec_data2;
            id_ex.immediate <= dec_imm;
            // bubble on stall or squash
            id_ex.ctrl      <= hz.id_ex_flush ? '0 : dec_ctrl;

            ex_mem.rd         <= id_ex.rd;
            ex_mem.alu_data   <= ex_alu_data;
            ex_mem.store_data <= ex_store_data;
            ex_mem.ctrl       <= id_ex.ctrl;

            mem_wb.rd        <= ex_mem.rd;
            mem_wb.load_data <= mem_load_data;
            mem_wb.alu_data  <= ex_mem.alu_data;
            mem_wb.ctrl      <= ex_mem.ctrl;
        end
    end

    assign wb_data = mem_wb.ctrl.mem_read ? mem_wb.load_data : mem_wb.alu_data;

    // commit trace, writes to x0 are not reported
    assign retire_valid = mem_wb.ctrl.reg_write && mem_wb.rd != '0;
    assign retire_rd    = mem_wb.rd;
    assign retire_data  = wb_data;

    assign store_valid = ex_mem.ctrl.mem_write;
    assign store_addr  = ex_mem.alu_data;
    assign store_data  = ex_mem.store_data;

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module decode_stage (
    input  wire logic                   clk,
    input  wire logic                   reset_n,
    input  wire rv_core_pkg::instr_t    instr,
    input  wire logic                   wb_en,
    input  wire logic [`REG_ADDR_W-1:0] wb_rd,
    input  wire logic [`XLEN-1:0]       wb_data,
    output logic      [`XLEN-1:0]       data1,
    output logic      [`XLEN-1:0]       data2,
    output logic      [`XLEN-1:0]       immediate,
    output rv_core_pkg::ctrl_t          ctrl
);

    import rv_core_pkg::*;

    logic [31:0]      raw;
    logic [`XLEN-1:0] regs [0:(1 << `REG_ADDR_W)-1];

    assign raw = instr;

    // x0 is never written, reads of it return zero below
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < (1 << `REG_ADDR_W); i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // write-first: a same-cycle writeback is visible to the read
    function automatic logic [`XLEN-1:0] read_reg(input logic [`REG_ADDR_W-1:0] idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb_en && wb_rd == idx) begin
            return wb_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        data1 = read_reg(instr.rs1);
        data2 = read_reg(instr.rs2);
    end

    // unsupported encodings fall through as bubbles
    always_comb begin
        ctrl = '0;
        case (instr.opcode)
            OPC_OP: begin
                ctrl.reg_write = 1'b1;
                case (instr.funct3)
                    3'b000: ctrl.alu_op = instr.funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b010: ctrl.alu_op = ALU_SLT;
                    3'b100: ctrl.alu_op = ALU_XOR;
                    3'b110: ctrl.alu_op = ALU_OR;
                    3'b111: ctrl.alu_op = ALU_AND;
                    default: ctrl = '0;
                endcase
            end
            OPC_OP_IMM: begin
                if (instr.funct3 == 3'b000) begin
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_src   = 1'b1;
                end
            end
            OPC_LOAD: begin
                if (instr.funct3 == 3'b010) begin
                    ctrl.reg_write = 1'b1;
                    ctrl.mem_read  = 1'b1;
                    ctrl.alu_src   = 1'b1;
                end
            end
            OPC_STORE: begin
                if (instr.funct3 == 3'b010) begin
                    ctrl.mem_write = 1'b1;
                    ctrl.alu_src   = 1'b1;
                end
            end
            OPC_BRANCH: begin
                if (instr.funct3[2:1] == 2'b00) begin
                    ctrl.is_branch = 1'b1;
                    ctrl.branch_ne = instr.funct3[0];
                    ctrl.alu_op    = ALU_SUB;
                end
            end
            default: ctrl = '0;
        endcase
    end

    // I, S or B format by opcode
    always_comb begin
        case (instr.opcode)
            OPC_STORE:  immediate = {{20{raw[31]}}, raw[31:25], raw[11:7]};
            OPC_BRANCH: immediate = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
            default:    immediate = {{20{raw[31]}}, raw[31:20]};
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module execute_stage (
    input  wire rv_core_pkg::id_ex_t  id_ex,
    hazard_if.dp                      hz,
    input  wire logic [`XLEN-1:0]     mem_fwd_data,
    input  wire logic [`XLEN-1:0]     wb_fwd_data,
    output logic      [`XLEN-1:0]     alu_data,
    output logic      [`XLEN-1:0]     store_data,
    output logic                      branch_taken,
    output logic      [`XLEN-1:0]     branch_target
);

    import rv_core_pkg::*;

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] fwd_b;
    logic [`XLEN-1:0] op_b;
    logic             equal;

    function automatic logic [`XLEN-1:0] select_operand(
        input fwd_sel_e         sel,
        input logic [`XLEN-1:0] reg_data
    );
        case (sel)
            FWD_MEM: return mem_fwd_data;
            FWD_WB:  return wb_fwd_data;
            default: return reg_data;
        endcase
    endfunction

    always_comb begin
        op_a  = select_operand(hz.forward_a, id_ex.data1);
        fwd_b = select_operand(hz.forward_b, id_ex.data2);
    end

    assign op_b       = id_ex.ctrl.alu_src ? id_ex.immediate : fwd_b;
    // store data is rs2 after forwarding, never the immediate
    assign store_data = fwd_b;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_SUB: alu_data = op_a - op_b;
            ALU_AND: alu_data = op_a & op_b;
            ALU_OR:  alu_data = op_a | op_b;
            ALU_XOR: alu_data = op_a ^ op_b;
            ALU_SLT: alu_data = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_data = op_a + op_b;
        endcase
    end

    // beq / bne resolve here
    assign equal         = (op_a == fwd_b);
    assign branch_taken  = id_ex.ctrl.is_branch & (equal ^ id_ex.ctrl.branch_ne);
    assign branch_target = id_ex.pc + id_ex.immediate;

endmodule

`default_nettype wire

//--- hdl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module fetch_stage (
    input  wire logic             clk,
    input  wire logic             reset_n,
    hazard_if.dp                  hz,
    input  wire logic             branch_taken,
    input  wire logic [`XLEN-1:0] branch_target,
    output logic      [`XLEN-1:0] pc
);

    logic [`XLEN-1:0] pc_next;

    // redirect wins over a load-use hold
    always_comb begin
        if (branch_taken) begin
            pc_next = branch_target;
        end else if (!hz.pc_write) begin
            pc_next = pc;
        end else begin
            pc_next = pc + `XLEN'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

//--- hdl/hazard_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module hazard_control (
    input  wire logic [`REG_ADDR_W-1:0] if_id_rs1,
    input  wire logic [`REG_ADDR_W-1:0] if_id_rs2,
    input  wire logic [`REG_ADDR_W-1:0] id_ex_rs1,
    input  wire logic [`REG_ADDR_W-1:0] id_ex_rs2,
    input  wire logic [`REG_ADDR_W-1:0] id_ex_rd,
    input  wire logic                   id_ex_mem_read,
    input  wire logic [`REG_ADDR_W-1:0] ex_mem_rd,
    input  wire logic                   ex_mem_reg_write,
    input  wire logic [`REG_ADDR_W-1:0] mem_wb_rd,
    input  wire logic                   mem_wb_reg_write,
    input  wire logic                   branch_taken,
    hazard_if.ctrl                      hz
);

    import rv_core_pkg::*;

    logic load_use;

    // younger result first, x0 never forwards
    function automatic fwd_sel_e pick_source(input logic [`REG_ADDR_W-1:0] rs);
        if (ex_mem_reg_write && ex_mem_rd != '0 && ex_mem_rd == rs) begin
            return FWD_MEM;
        end
        if (mem_wb_reg_write && mem_wb_rd != '0 && mem_wb_rd == rs) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        hz.forward_a = pick_source(id_ex_rs1);
        hz.forward_b = pick_source(id_ex_rs2);
    end

    // load result not ready until after mem
    assign load_use = id_ex_mem_read && id_ex_rd != '0 &&
                      (id_ex_rd == if_id_rs1 || id_ex_rd == if_id_rs2);

    // a taken branch squashes both younger slots, so any stall is moot
    assign hz.pc_write    = branch_taken | ~load_use;
    assign hz.if_id_write = branch_taken | ~load_use;
    assign hz.if_id_flush = branch_taken;
    assign hz.id_ex_flush = branch_taken | load_use;

endmodule

`default_nettype wire

//--- hdl/hazard_if.sv
`timescale 1ns/1ps
`default_nettype none

// pipeline control from the hazard unit to the datapath
interface hazard_if;

    import rv_core_pkg::*;

    logic     pc_write;
    logic     if_id_write;
    logic     if_id_flush;
    logic     id_ex_flush;
    fwd_sel_e forward_a;
    fwd_sel_e forward_b;

    modport ctrl (
        output pc_write,
        output if_id_write,
        output if_id_flush,
        output id_ex_flush,
        output forward_a,
        output forward_b
    );

    modport dp (
        input pc_write,
        input if_id_write,
        input if_id_flush,
        input id_ex_flush,
        input forward_a,
        input forward_b
    );

endinterface

`default_nettype wire

//--- hdl/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module mem_stage (
    input  wire logic                 clk,
    input  wire rv_core_pkg::ex_mem_t ex_mem,
    output logic      [`XLEN-1:0]     load_data
);

    logic [`XLEN-1:0]        mem [0:(1 << `DMEM_ADDR_W)-1];
    logic [`DMEM_ADDR_W-1:0] word_addr;

    // word accesses only, byte offset ignored
    assign word_addr = ex_mem.alu_data[`DMEM_ADDR_W+1:2];

    always_ff @(posedge clk) begin
        if (ex_mem.ctrl.mem_write) begin
            mem[word_addr] <= ex_mem.store_data;
        end
    end

    assign load_data = mem[word_addr];

endmodule

`default_nettype wire

//--- hdl/program_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module program_memory (
    input  wire logic                    clk,
    input  wire logic                    load_en,
    input  wire logic [`IMEM_ADDR_W-1:0] load_addr,
    input  wire logic [`XLEN-1:0]        load_data,
    input  wire logic [`IMEM_ADDR_W-1:0] read_addr,
    output logic      [`XLEN-1:0]        read_data
);

    logic [`XLEN-1:0] mem [0:(1 << `IMEM_ADDR_W)-1];

    // filled word by word while the core sits in reset
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // combinational read so fetch gets the word in the same cycle
    assign read_data = mem[read_addr];

endmodule

`default_nettype wire

//--- hdl/rv_core_pkg.sv
`default_nettype none

`include "rv_core_macros.svh"

package rv_core_pkg;

    // major opcodes of the kept subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

    // operand source seen by execute
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwd_sel_e;

    // R-type field view, other formats are sliced from the raw word
    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } instr_t;

    // all zero means bubble
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src;
        alu_op_e alu_op;
        logic    is_branch;
        logic    branch_ne;
    } ctrl_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        instr_t           instr;
    } if_id_t;

    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data1;
        logic [`XLEN-1:0]       data2;
        logic [`XLEN-1:0]       immediate;
        ctrl_t                  ctrl;
    } id_ex_t;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       alu_data;
        logic [`XLEN-1:0]       store_data;
        ctrl_t                  ctrl;
    } ex_mem_t;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       load_data;
        logic [`XLEN-1:0]       alu_data;
        ctrl_t                  ctrl;
    } mem_wb_t;

endpackage

`default_nettype wire

//--- include/rv_core_macros.svh
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// datapath width
`define XLEN 32

// register index width, 32 registers
`define REG_ADDR_W 5

// instruction memory, word addressed
`define IMEM_ADDR_W 8

// data memory, word addressed
`define DMEM_ADDR_W 8

`endif

//--- verif/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module cpu_tb;

    localparam int NUM_TESTS  = 12;
    localparam int MAX_LEN    = 40;
    localparam int DRAIN      = 8;
    localparam int IMEM_WORDS = 1 << `IMEM_ADDR_W;
    // per test: load, reset tail, run limit and drain
    localparam int WATCHDOG   = NUM_TESTS * (IMEM_WORDS + 8 + 3 * MAX_LEN + 20 + DRAIN);

    logic                    clk;
    logic                    reset_n;
    logic                    imem_load_en;
    logic [`IMEM_ADDR_W-1:0] imem_load_addr;
    logic [`XLEN-1:0]        imem_load_data;
    logic                    retire_valid;
    logic [`REG_ADDR_W-1:0]  retire_rd;
    logic [`XLEN-1:0]        retire_data;
    logic                    store_valid;
    logic [`XLEN-1:0]        store_addr;
    logic [`XLEN-1:0]        store_data;

    integer      seed = 32'h8f67;
    logic [31:0] prog [0:MAX_LEN-1];
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_data_q [$];
    logic [31:0] exp_addr_q [$];
    logic [31:0] exp_sdata_q [$];
    // data words a load may safely read, set by stores no branch can skip
    logic        known [0:15];
    int          shadow_end;
    int          test_errors;
    int          test_retired;
    int          test_stores;
    int          failed_tests;
    int          total_errors;
    int          total_cycles = 0;

    cpu UUT (
        .clk            (clk),
        .reset_n        (reset_n),
        .imem_load_en   (imem_load_en),
        .imem_load_addr (imem_load_addr),
        .imem_load_data (imem_load_data),
        .retire_valid   (retire_valid),
        .retire_rd      (retire_rd),
        .retire_data    (retire_data),
        .store_valid    (store_valid),
        .store_addr     (store_addr),
        .store_data     (store_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        total_cycles++;
        if (total_cycles > WATCHDOG) begin
            $display("watchdog expired after %0d cycles, the run did not finish", total_cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic int rand_below(input int lim);
        return ($random(seed) & 32'h7fff_ffff) % lim;
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'(1 + rand_below(7));
    endfunction

    function automatic logic [31:0] seed_word(input logic [4:0] rd);
        return {12'(rand_below(4096)), 5'd0, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] alu_word(input logic [4:0] rd, rs1, rs2);
        logic [11:0] imm;
        imm = 12'(rand_below(4096));
        case (rand_below(7))
            0: return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            1: return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            2: return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
            3: return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            4: return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
            5: return {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
            default: return {imm, rs1, 3'b000, rd, 7'b0010011};
        endcase
    endfunction

    function automatic logic [31:0] store_word(input int i, input logic [4:0] rs2);
        int          off;
        logic [11:0] imm;
        off = rand_below(16);
        if (i >= shadow_end) begin
            known[off] = 1'b1;
        end
        imm = 12'(off * 4);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // falls back to a store while no address is known
    function automatic logic [31:0] load_word(input int i, input logic [4:0] rd);
        int start;
        start = rand_below(16);
        for (int k = 0; k < 16; k++) begin
            if (known[(start + k) % 16]) begin
                return {12'(((start + k) % 16) * 4), 5'd0, 3'b010, rd, 7'b0000011};
            end
        end
        return store_word(i, rand_reg());
    endfunction

    // forward only, skipping one to three instructions
    function automatic logic [31:0] branch_word(input int i, input int n);
        int          tgt;
        logic [12:0] imm;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        tgt = i + 2 + rand_below(3);
        if (tgt > n) begin
            tgt = n;
        end
        if (tgt > shadow_end) begin
            shadow_end = tgt;
        end
        imm = 13'((tgt - i) * 4);
        rs1 = rand_reg();
        // equal operands now and then so BEQ gets taken
        rs2 = (rand_below(3) == 0) ? rs1 : rand_reg();
        return {imm[12], imm[10:5], rs2, rs1, 2'b00, 1'(rand_below(2)),
                imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic string mode_name(input int mode);
        case (mode)
            0: return "independent alu";
            1: return "forwarding";
            2: return "load-use";
            3: return "branches";
            default: return "random mix";
        endcase
    endfunction

    task automatic gen_program(input int mode, input int n);
        logic [4:0] rd;
        logic [4:0] src;
        logic [4:0] ld_rd;
        int         kind;
        shadow_end = 0;
        src = 5'd1;
        ld_rd = 5'd1;
        for (int k = 0; k < 16; k++) begin
            known[k] = 1'b0;
        end
        for (int i = 0; i < n; i++) begin
            rd = 5'(i % 7 + 1);
            kind = rand_below(10);
            if (mode != 2 && i < 7) begin
                prog[i] = seed_word(rd);
            end else begin
                case (mode)
                    // sources only from results at least four back
                    0: prog[i] = alu_word(rd, 5'((i + rand_below(4)) % 7 + 1),
                                          5'((i + rand_below(4)) % 7 + 1));
                    // rs1 is the result from one, two or three back
                    1: prog[i] = alu_word(rd, 5'((i + 6 - i % 3) % 7 + 1), rand_reg());
                    2: begin
                        case (i % 4)
                            0: begin
                                src = rand_reg();
                                prog[i] = seed_word(src);
                            end
                            1: prog[i] = store_word(i, src);
                            2: begin
                                ld_rd = rand_reg();
                                prog[i] = load_word(i, ld_rd);
                            end
                            default: prog[i] = alu_word(rand_reg(), ld_rd, rand_reg());
                        endcase
                    end
                    3: begin
                        if (i % 3 == 0) begin
                            prog[i] = branch_word(i, n);
                        end else if (kind < 7) begin
                            prog[i] = alu_word(rd, rand_reg(), rand_reg());
                        end else begin
                            prog[i] = store_word(i, rand_reg());
                        end
                    end
                    default: begin
                        if (kind < 5) begin
                            prog[i] = alu_word(rd, rand_reg(), rand_reg());
                        end else if (kind == 5) begin
                            prog[i] = store_word(i, rand_reg());
                        end else if (kind < 8) begin
                            prog[i] = load_word(i, rd);
                        end else begin
                            prog[i] = branch_word(i, n);
                        end
                    end
                endcase
            end
        end
    endtask

    // architectural run of the program, one instruction at a time
    task automatic run_model(input int n);
        logic [31:0] regs [0:31];
        logic [31:0] dmem [0:15];
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic        wr;
        int          pc;
        exp_rd_q.delete();
        exp_data_q.delete();
        exp_addr_q.delete();
        exp_sdata_q.delete();
        for (int k = 0; k < 32; k++) begin
            regs[k] = '0;
            dmem[k % 16] = '0;
        end
        pc = 0;
        while (pc < n) begin
            w = prog[pc];
            a = regs[w[19:15]];
            b = regs[w[24:20]];
            imm_i = {{20{w[31]}}, w[31:20]};
            imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
            imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            wr = 1'b1;
            res = '0;
            pc = pc + 1;
            case (w[6:0])
                7'b0110011: begin
                    case (w[14:12])
                        3'b000: res = w[30] ? a - b : a + b;
                        3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'b100: res = a ^ b;
                        3'b110: res = a | b;
                        default: res = a & b;
                    endcase
                end
                7'b0010011: res = a + imm_i;
                7'b0000011: begin
                    addr = a + imm_i;
                    res = dmem[addr[5:2]];
                end
                7'b0100011: begin
                    wr = 1'b0;
                    addr = a + imm_s;
                    dmem[addr[5:2]] = b;
                    exp_addr_q.push_back(addr);
                    exp_sdata_q.push_back(b);
                end
                7'b1100011: begin
                    wr = 1'b0;
                    // funct3 bit 0 selects BNE
                    if ((a == b) != w[12]) begin
                        pc = pc - 1 + int'(imm_b[31:2]);
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && w[11:7] != 5'd0) begin
                regs[w[11:7]] = res;
                exp_rd_q.push_back(w[11:7]);
                exp_data_q.push_back(res);
            end
        end
    endtask

    // reset spans the whole load plus three more cycles
    task automatic load_program(input int n);
        @(negedge clk);
        reset_n = 1'b0;
        for (int a = 0; a < IMEM_WORDS; a++) begin
            imem_load_en = 1'b1;
            imem_load_addr = `IMEM_ADDR_W'(a);
            imem_load_data = (a < n) ? prog[a] : '0;
            @(negedge clk);
        end
        imem_load_en = 1'b0;
        repeat (3) @(negedge clk);
        reset_n = 1'b1;
    endtask

    task automatic check_outputs();
        logic [4:0]  e_rd;
        logic [31:0] e_data;
        logic [31:0] e_addr;
        logic [31:0] e_sdata;
        if (retire_valid === 1'b1) begin
            test_retired++;
            if (exp_rd_q.size() == 0) begin
                $display("unexpected retirement of x%0d at time %0t", retire_rd, $time);
                test_errors++;
            end else begin
                e_rd = exp_rd_q.pop_front();
                e_data = exp_data_q.pop_front();
                if (retire_rd !== e_rd || retire_data !== e_data) begin
                    $display("CHECK FAILED at time %0t: retired x%0d = %h, expected x%0d = %h",
                             $time, retire_rd, retire_data, e_rd, e_data);
                    test_errors++;
                end
            end
        end
        if (store_valid === 1'b1) begin
            test_stores++;
            if (exp_addr_q.size() == 0) begin
                $display("unexpected store to %h at time %0t", store_addr, $time);
                test_errors++;
            end else begin
                e_addr = exp_addr_q.pop_front();
                e_sdata = exp_sdata_q.pop_front();
                if (store_addr !== e_addr || store_data !== e_sdata) begin
                    $display("CHECK FAILED at time %0t: store %h to %h, expected %h to %h",
                             $time, store_data, store_addr, e_sdata, e_addr);
                    test_errors++;
                end
            end
        end
    endtask

    task automatic run_test(input int n);
        int cycles;
        cycles = 0;
        while ((exp_rd_q.size() != 0 || exp_addr_q.size() != 0) && cycles < 3 * n + 20) begin
            @(negedge clk);
            check_outputs();
            cycles++;
        end
        if (exp_rd_q.size() != 0 || exp_addr_q.size() != 0) begin
            $display("timed out after %0d cycles, %0d retirements and %0d stores never seen",
                     cycles, exp_rd_q.size(), exp_addr_q.size());
            test_errors++;
        end
        // nothing else may retire or store once the model is exhausted
        repeat (DRAIN) begin
            @(negedge clk);
            check_outputs();
        end
    endtask

    initial begin
        int mode;
        int len;
        reset_n = 1'b0;
        imem_load_en = 1'b0;
        imem_load_addr = '0;
        imem_load_data = '0;
        failed_tests = 0;
        total_errors = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            mode = (t < 4) ? t : 4;
            len = (t < 4) ? 24 : MAX_LEN;
            test_errors = 0;
            test_retired = 0;
            test_stores = 0;
            gen_program(mode, len);
            run_model(len);
            load_program(len);
            run_test(len);
            $display("test %0d %s: %0d retired, %0d stores, %0d errors",
                     t + 1, mode_name(mode), test_retired, test_stores, test_errors);
            if (test_errors != 0) begin
                failed_tests++;
            end
            total_errors += test_errors;
        end
        $display("%0d tests run, %0d failed, %0d errors in all",
                 NUM_TESTS, failed_tests, total_errors);
        if (total_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
